// File: Bender.yml
package:
  name: rename_iq
  authors: []

sources:
  # package first, then the RTL from the leaves up
  - logic/rename_pkg.sv
  - logic/preg_free_list.sv
  - logic/iq_rename_line.sv
  - logic/issue_queue.sv
  - logic/issue_select.sv
  - logic/rename_iq_top.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_rename_iq.sv

// File: logic/iq_rename_line.sv
`timescale 1ns/1ps

module iq_rename_line (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    load_i,
  input  rename_pkg::iq_line_t    line_i,
  input  rename_pkg::rename_map_t map_i,
  input  rename_pkg::wb_t         wb_i,
  output rename_pkg::rename_map_t map_o,
  output rename_pkg::map_entry_t  psrc1_o,
  output rename_pkg::map_entry_t  psrc2_o,
  output rename_pkg::iq_line_t    line_o
);

  import rename_pkg::*;

  // tag returned for a source that is not read
  localparam map_entry_t READY_ENTRY = '{rdy: 1'b1, preg: '0};

  logic     valid_q;
  iq_line_t data_q;
  logic     dst_rdy_q;
  logic     dst_rdy_d;
  // line owns a destination mapping
  logic     writes_q;
  logic     writes_in;

  assign writes_q  = valid_q && data_q.ins.dst_vld;
  assign writes_in = line_i.ins.valid && line_i.ins.dst_vld;

  ////////////////////////////////////////////////////////////////////////////
  // line storage
  ////////////////////////////////////////////////////////////////////////////

  // valid bit is control, the rest is payload
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      valid_q <= 1'b0;
    else if (load_i)
      valid_q <= line_i.ins.valid;
  end

  always_ff @(posedge clk)
  begin
    if (load_i)
      data_q <= line_i;
  end

  // destination ready
  // fresh dispatch comes in cleared, a shifted line keeps what it had
  // a writeback on the load edge still counts for the incoming line
  always_comb
  begin
    if (load_i)
      dst_rdy_d = !writes_in || line_i.dst_rdy || wb_hit(wb_i, line_i.pdst);
    else
      dst_rdy_d = !writes_q || dst_rdy_q || wb_hit(wb_i, data_q.pdst);
  end

  // empty line holds the flop set so nothing behind it waits
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      dst_rdy_q <= 1'b1;
    else
      dst_rdy_q <= dst_rdy_d;
  end

  ////////////////////////////////////////////////////////////////////////////
  // source rename, combinational from the older mapping
  ////////////////////////////////////////////////////////////////////////////

  // unused source or empty line reads as ready
  assign psrc1_o = (valid_q && data_q.ins.src1_vld) ? map_i[data_q.ins.lsrc1] : READY_ENTRY;
  assign psrc2_o = (valid_q && data_q.ins.src2_vld) ? map_i[data_q.ins.lsrc2] : READY_ENTRY;

  // younger lines see this destination in place of the older one
  always_comb
  begin
    map_o = map_i;
    if (writes_q)
      map_o[data_q.ins.ldst] = '{rdy: dst_rdy_q, preg: data_q.pdst};
  end

  // stored line with the live control bits folded back in
  always_comb
  begin
    line_o           = data_q;
    line_o.ins.valid = valid_q;
    line_o.dst_rdy   = dst_rdy_q;
  end

endmodule

// File: logic/issue_queue.sv
`timescale 1ns/1ps

module issue_queue #(
  parameter int IQ_DEPTH = 4
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  rename_pkg::instr_t            dispatch_i,
  input  logic [rename_pkg::PREG_W-1:0] alloc_preg_i,
  input  logic                          free_not_empty_i,
  output logic                          alloc_take_o,
  output logic                          dispatch_ready_o,
  input  rename_pkg::wb_t               wb_i,
  input  logic                          issue_take_i,
  output logic                          head_ready_o,
  output rename_pkg::iq_line_t          head_line_o,
  output rename_pkg::map_entry_t        head_psrc1_o,
  output rename_pkg::map_entry_t        head_psrc2_o
);

  import rename_pkg::*;

  localparam int CNT_W = $clog2(IQ_DEPTH + 1);

  rename_map_t         commit_map_q;
  // map seen by each line, last one is the newest mapping
  rename_map_t         map_chain [IQ_DEPTH+1];
  // one extra empty line shifts in above the tail
  iq_line_t            line_out  [IQ_DEPTH+1];
  iq_line_t            line_in   [IQ_DEPTH];
  map_entry_t          psrc1     [IQ_DEPTH];
  map_entry_t          psrc2     [IQ_DEPTH];
  logic [IQ_DEPTH-1:0] load;
  logic [CNT_W-1:0]    count_q;
  logic [CNT_W-1:0]    tail_idx;
  logic                accept;
  iq_line_t            new_line;

  // set ready on every entry the writeback completes
  function automatic rename_map_t apply_wb(rename_map_t map, wb_t wb);
    rename_map_t res;
    res = map;
    for (int i = 0; i < NUM_LREG; i++)
    begin
      if (wb_hit(wb, map[i].preg))
        res[i].rdy = 1'b1;
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // dispatch side
  ////////////////////////////////////////////////////////////////////////////

  assign dispatch_ready_o = (count_q < CNT_W'(IQ_DEPTH)) &&
                            (!dispatch_i.dst_vld || free_not_empty_i);
  assign accept       = dispatch_i.valid && dispatch_ready_o;
  assign alloc_take_o = accept && dispatch_i.dst_vld;

  // empty lines pass the map through, so the chain end is the tail's view
  always_comb
  begin
    new_line.ins     = dispatch_i;
    new_line.dst_rdy = 1'b0;
    new_line.pdst    = dispatch_i.dst_vld ? alloc_preg_i : '0;
    new_line.stale   = map_chain[IQ_DEPTH][dispatch_i.ldst].preg;
  end

  // tail moves down one slot when the head leaves on the same edge
  assign tail_idx = issue_take_i ? count_q - 1'b1 : count_q;

  // issue shifts every line, otherwise only the tail slot is written
  always_comb
  begin
    for (int k = 0; k < IQ_DEPTH; k++)
    begin
      load[k]    = 1'b0;
      line_in[k] = new_line;
      if (issue_take_i)
      begin
        load[k] = 1'b1;
        if (!(accept && (CNT_W'(k) == tail_idx)))
          line_in[k] = line_out[k+1];
      end
      else if (accept && (CNT_W'(k) == count_q))
      begin
        load[k] = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // occupancy and committed map
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      count_q <= '0;
      // identity map, everything ready
      for (int i = 0; i < NUM_LREG; i++)
        commit_map_q[i] <= '{rdy: 1'b1, preg: PREG_W'(i)};
    end
    else
    begin
      count_q <= count_q + CNT_W'(accept) - CNT_W'(issue_take_i);
      // leaving head hands its mapping to the committed map
      commit_map_q <= apply_wb(issue_take_i ? map_chain[1] : commit_map_q, wb_i);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // line chain
  ////////////////////////////////////////////////////////////////////////////

  assign map_chain[0]       = commit_map_q;
  assign line_out[IQ_DEPTH] = '0;

  for (genvar k = 0; k < IQ_DEPTH; k++)
  begin : g_line
    iq_rename_line u_line (
      .clk     (clk),
      .rst_n   (rst_n),
      .load_i  (load[k]),
      .line_i  (line_in[k]),
      .map_i   (map_chain[k]),
      .wb_i    (wb_i),
      .map_o   (map_chain[k+1]),
      .psrc1_o (psrc1[k]),
      .psrc2_o (psrc2[k]),
      .line_o  (line_out[k])
    );
  end

  // only the head may leave
  assign head_line_o  = line_out[0];
  assign head_psrc1_o = psrc1[0];
  assign head_psrc2_o = psrc2[0];
  assign head_ready_o = psrc1[0].rdy && psrc2[0].rdy;

endmodule

// File: logic/issue_select.sv
`timescale 1ns/1ps

module issue_select (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   head_ready_i,
  input  rename_pkg::iq_line_t   head_line_i,
  input  rename_pkg::map_entry_t head_psrc1_i,
  input  rename_pkg::map_entry_t head_psrc2_i,
  output logic                   issue_take_o,
  output rename_pkg::issue_t     issue_o
);

  import rename_pkg::*;

  logic   valid_q;
  issue_t pkt_q;
  issue_t pkt_d;

  ////////////////////////////////////////////////////////////////////////////
  // take decision
  ////////////////////////////////////////////////////////////////////////////

  // empty head reads ready, so the valid bit gates it
  // the queue shifts on this edge, next cycle shows a new head
  assign issue_take_o = head_line_i.ins.valid && head_ready_i;

  // packet built from the head line and its renamed sources
  always_comb
  begin
    pkt_d.valid   = 1'b1;
    pkt_d.payload = head_line_i.ins.payload;
    pkt_d.pdst    = head_line_i.pdst;
    pkt_d.dst_vld = head_line_i.ins.dst_vld;
    pkt_d.psrc1   = head_psrc1_i.preg;
    pkt_d.psrc2   = head_psrc2_i.preg;
    pkt_d.stale   = head_line_i.stale;
  end

  ////////////////////////////////////////////////////////////////////////////
  // issue register
  ////////////////////////////////////////////////////////////////////////////

  // valid is a one-cycle pulse
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      valid_q <= 1'b0;
    else
      valid_q <= issue_take_o;
  end

  always_ff @(posedge clk)
  begin
    if (issue_take_o)
      pkt_q <= pkt_d;
  end

  always_comb
  begin
    issue_o       = pkt_q;
    issue_o.valid = valid_q;
  end

endmodule

// File: logic/preg_free_list.sv
`timescale 1ns/1ps

module preg_free_list (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          alloc_take_i,
  output logic [rename_pkg::PREG_W-1:0] alloc_preg_o,
  output logic                          not_empty_o,
  input  rename_pkg::wb_t               wb_i
);

  import rename_pkg::*;

  localparam int PTR_W = $clog2(NUM_PREG);
  localparam int CNT_W = PTR_W + 1;

  // storage for free indices, one slot per physical register
  logic [PREG_W-1:0] fifo_mem [NUM_PREG];
  logic [PTR_W-1:0]  rd_ptr;
  logic [PTR_W-1:0]  wr_ptr;
  logic [CNT_W-1:0]  count;
  logic              pop;
  logic              push;

  ////////////////////////////////////////////////////////////////////////////
  // pop and push strobes
  ////////////////////////////////////////////////////////////////////////////

  // dispatch only takes a register when one is there
  assign pop  = alloc_take_i && not_empty_o;
  // stale register comes back on the writeback cycle
  assign push = wb_i.valid && wb_i.free_vld;

  // oldest free index is always at the read pointer
  assign alloc_preg_o = fifo_mem[rd_ptr];
  assign not_empty_o  = (count != '0);

  ////////////////////////////////////////////////////////////////////////////
  // circular buffer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      // registers 0..15 are held by the reset map
      // slots 0..47 then hold 16..63, the rest is past the write pointer
      for (int i = 0; i < NUM_PREG; i++)
      begin
        fifo_mem[i] <= PREG_W'(i + NUM_LREG);
      end
      rd_ptr <= '0;
      wr_ptr <= PTR_W'(NUM_PREG - NUM_LREG);
      count  <= CNT_W'(NUM_PREG - NUM_LREG);
    end
    else
    begin
      if (push)
      begin
        fifo_mem[wr_ptr] <= wb_i.stale;
        // pointer wraps on its own, depth is a power of two
        wr_ptr           <= wr_ptr + 1'b1;
      end
      if (pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // both at once leaves the count alone
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

endmodule

// File: logic/rename_iq_top.sv
`timescale 1ns/1ps

module rename_iq_top #(
  parameter int IQ_DEPTH = 4
) (
  input  logic               clk,
  input  logic               rst_n,
  input  rename_pkg::instr_t dispatch_i,
  output logic               dispatch_ready_o,
  input  rename_pkg::wb_t    wb_i,
  output rename_pkg::issue_t issue_o
);

  import rename_pkg::*;

  // free list to queue
  logic [PREG_W-1:0] alloc_preg;
  logic              free_not_empty;
  logic              alloc_take;
  // queue to selector and back
  logic              head_ready;
  logic              issue_take;
  iq_line_t          head_line;
  map_entry_t        head_psrc1;
  map_entry_t        head_psrc2;

  ////////////////////////////////////////////////////////////////////////////
  // producer, buffer, consumer
  ////////////////////////////////////////////////////////////////////////////

  // writeback releases the stale register here
  preg_free_list u_free_list (
    .clk          (clk),
    .rst_n        (rst_n),
    .alloc_take_i (alloc_take),
    .alloc_preg_o (alloc_preg),
    .not_empty_o  (free_not_empty),
    .wb_i         (wb_i)
  );

  // same writeback sets ready bits across the queue
  issue_queue #(
    .IQ_DEPTH (IQ_DEPTH)
  ) u_queue (
    .clk              (clk),
    .rst_n            (rst_n),
    .dispatch_i       (dispatch_i),
    .alloc_preg_i     (alloc_preg),
    .free_not_empty_i (free_not_empty),
    .alloc_take_o     (alloc_take),
    .dispatch_ready_o (dispatch_ready_o),
    .wb_i             (wb_i),
    .issue_take_i     (issue_take),
    .head_ready_o     (head_ready),
    .head_line_o      (head_line),
    .head_psrc1_o     (head_psrc1),
    .head_psrc2_o     (head_psrc2)
  );

  issue_select u_select (
    .clk          (clk),
    .rst_n        (rst_n),
    .head_ready_i (head_ready),
    .head_line_i  (head_line),
    .head_psrc1_i (head_psrc1),
    .head_psrc2_i (head_psrc2),
    .issue_take_o (issue_take),
    .issue_o      (issue_o)
  );

endmodule

// File: logic/rename_pkg.sv
package rename_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////////////////////

  // architectural register file seen by the core
  parameter int NUM_LREG = 16;
  // physical register file behind the rename map
  parameter int NUM_PREG = 64;
  parameter int PREG_W   = 6;
  parameter int LREG_W   = 4;

  ////////////////////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////////////////////

  // one logical register mapping, ready bit on top
  typedef struct packed {
    logic              rdy;
    logic [PREG_W-1:0] preg;
  } map_entry_t;

  // full map, entry 0 sits in the low bits
  typedef map_entry_t [NUM_LREG-1:0] rename_map_t;

  // dispatched instruction, payload is opcode plus immediate and not decoded here
  typedef struct packed {
    logic              valid;
    logic              dst_vld;
    logic [LREG_W-1:0] ldst;
    logic              src1_vld;
    logic [LREG_W-1:0] lsrc1;
    logic              src2_vld;
    logic [LREG_W-1:0] lsrc2;
    logic [15:0]       payload;
  } instr_t;

  // one queue line
  // dst_rdy follows the line as it moves toward the head
  typedef struct packed {
    instr_t            ins;
    logic              dst_rdy;
    logic [PREG_W-1:0] pdst;
    logic [PREG_W-1:0] stale;
  } iq_line_t;

  // packet leaving the queue
  typedef struct packed {
    logic              valid;
    logic [15:0]       payload;
    logic [PREG_W-1:0] pdst;
    logic              dst_vld;
    logic [PREG_W-1:0] psrc1;
    logic [PREG_W-1:0] psrc2;
    logic [PREG_W-1:0] stale;
  } issue_t;

  // completion from outside, free_vld says whether stale goes back to the free list
  typedef struct packed {
    logic              valid;
    logic [PREG_W-1:0] preg;
    logic              free_vld;
    logic [PREG_W-1:0] stale;
  } wb_t;

  // true when a writeback completes the given physical register
  function automatic logic wb_hit(wb_t wb, logic [PREG_W-1:0] preg);
    return wb.valid && (wb.preg == preg);
  endfunction

endpackage

// File: rename_iq_top.f
logic/rename_pkg.sv
logic/preg_free_list.sv
logic/iq_rename_line.sv
logic/issue_queue.sv
logic/issue_select.sv
logic/rename_iq_top.sv
testbench/tb_clk_gen.sv
testbench/tb_rename_iq.sv

// File: testbench/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 8 ns period
  initial
  begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // reset low over five rising edges, released right after the fifth
  initial
  begin
    rst_n_o = 1'b0;
    repeat (5) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// File: testbench/tb_rename_iq.sv
`timescale 1ns/1ps

module tb_rename_iq;

  import rename_pkg::*;

  localparam logic [1:0] OP_DISP   = 2'd0;
  localparam logic [1:0] OP_WB     = 2'd1;
  localparam logic [1:0] OP_IDLE   = 2'd2;
  localparam logic [1:0] OP_SETTLE = 2'd3;
  localparam int         MAX_SEQ   = 128;

  // one stimulus row, seq names the dispatched instruction a writeback completes
  typedef struct packed {
    logic [1:0] op;
    instr_t     ins;
    logic [7:0] seq;
    logic       exp_rdy;
  } row_t;

  logic   clk;
  logic   rst_n;
  instr_t dispatch;
  logic   dispatch_ready;
  wb_t    wb;
  issue_t issue;

  row_t        rows [$];
  string       row_name [$];
  int          cycles;
  int          limit;
  logic [31:0] lfsr_state;

  ////////////////////////////////////////////////////////////////////////////
  // reference rename model
  ////////////////////////////////////////////////////////////////////////////

  logic [PREG_W-1:0]   map_p [NUM_LREG];
  logic [NUM_PREG-1:0] preg_rdy;
  logic [PREG_W-1:0]   free_q [$];
  int                  n_disp;
  // what each dispatched instruction got
  logic [PREG_W-1:0]   rec_pdst [MAX_SEQ];
  logic [PREG_W-1:0]   rec_stale [MAX_SEQ];
  logic [PREG_W-1:0]   rec_p1 [MAX_SEQ];
  logic [PREG_W-1:0]   rec_p2 [MAX_SEQ];
  logic                rec_dst [MAX_SEQ];
  logic                rec_s1v [MAX_SEQ];
  logic                rec_s2v [MAX_SEQ];
  string               rec_name [MAX_SEQ];
  // packets the DUT still owes, oldest first
  issue_t              exp_pkt [$];
  int                  exp_seq [$];

  tb_clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  rename_iq_top #(
    .IQ_DEPTH (4)
  ) u_dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .dispatch_i       (dispatch),
    .dispatch_ready_o (dispatch_ready),
    .wb_i             (wb),
    .issue_o          (issue)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_issue(input string name, input issue_t exp, input issue_t act);
    if (act !== exp)
      abort_run($sformatf("ERR %s issue expected %h actual %h", name, exp, act));
  endtask

  task automatic check_ready(input string name, input logic exp, input logic act);
    if (act !== exp)
      abort_run($sformatf("ERR %s dispatch_ready expected %b actual %b", name, exp, act));
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // one step per payload bit
  task automatic next_payload(output logic [15:0] pl);
    pl = '0;
    for (int b = 0; b < 16; b++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      pl = {pl[14:0], lfsr_state[0]};
    end
  endtask

  function automatic instr_t make_instr(input logic dv, input int ld, input logic s1v,
                                        input int l1, input logic s2v, input int l2);
    instr_t ins;
    ins          = '0;
    ins.dst_vld  = dv;
    ins.ldst     = LREG_W'(ld);
    ins.src1_vld = s1v;
    ins.lsrc1    = LREG_W'(l1);
    ins.src2_vld = s2v;
    ins.lsrc2    = LREG_W'(l2);
    return ins;
  endfunction

  task automatic add_row(input string name, input logic [1:0] op, input instr_t ins,
                         input int seq, input logic exp_rdy);
    row_t r;
    r.op      = op;
    r.ins     = ins;
    r.seq     = 8'(seq);
    r.exp_rdy = exp_rdy;
    rows.push_back(r);
    row_name.push_back(name);
  endtask

  // oldest owed instruction has all of its used sources written back
  function automatic logic front_ready();
    int s;
    s = exp_seq[0];
    return (!rec_s1v[s] || preg_rdy[rec_p1[s]]) && (!rec_s2v[s] || preg_rdy[rec_p2[s]]);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // cycle stepping and issue monitor
  ////////////////////////////////////////////////////////////////////////////

  task automatic observe_issue();
    int s;
    if (issue.valid !== 1'b0)
    begin
      if (exp_seq.size() == 0)
        abort_run("issue pulse seen with no instruction left to issue");
      else
      begin
        s = exp_seq[0];
        // in-order issue, so the packet belongs to the oldest owed instruction
        if (!front_ready())
          abort_run($sformatf("%s issued before its sources were written back",
                              rec_name[s]));
        else
        begin
          check_issue(rec_name[s], exp_pkt[0], issue);
          void'(exp_pkt.pop_front());
          void'(exp_seq.pop_front());
        end
      end
    end
  endtask

  // falling edge, strobes drop back to idle unless the row drives them again
  task automatic advance_cycle();
    @(negedge clk);
    cycles++;
    if (cycles > limit)
      abort_run($sformatf("timeout after %0d cycles, the DUT stopped issuing", cycles));
    else
    begin
      observe_issue();
      dispatch = '0;
      wb       = '0;
    end
  endtask

  task automatic rename_dispatch(input instr_t ins, input string name);
    issue_t pkt;
    int     s;
    s           = n_disp;
    pkt.valid   = 1'b1;
    pkt.payload = ins.payload;
    pkt.dst_vld = ins.dst_vld;
    // unused sources carry index 0
    pkt.psrc1   = ins.src1_vld ? map_p[ins.lsrc1] : '0;
    pkt.psrc2   = ins.src2_vld ? map_p[ins.lsrc2] : '0;
    pkt.stale   = map_p[ins.ldst];
    pkt.pdst    = '0;
    if (ins.dst_vld)
    begin
      pkt.pdst            = free_q.pop_front();
      preg_rdy[pkt.pdst]  = 1'b0;
      map_p[ins.ldst]     = pkt.pdst;
    end
    rec_pdst[s]  = pkt.pdst;
    rec_stale[s] = pkt.stale;
    rec_p1[s]    = pkt.psrc1;
    rec_p2[s]    = pkt.psrc2;
    rec_dst[s]   = ins.dst_vld;
    rec_s1v[s]   = ins.src1_vld;
    rec_s2v[s]   = ins.src2_vld;
    rec_name[s]  = name;
    exp_pkt.push_back(pkt);
    exp_seq.push_back(s);
    n_disp++;
  endtask

  // completion frees the register its instruction made stale
  task automatic complete_wb(input int s);
    wb.valid    = 1'b1;
    wb.preg     = rec_pdst[s];
    wb.free_vld = rec_dst[s];
    wb.stale    = rec_stale[s];
    preg_rdy[rec_pdst[s]] = 1'b1;
    if (rec_dst[s])
      free_q.push_back(rec_stale[s]);
  endtask

  task automatic apply_row(input int i);
    row_t        r;
    instr_t      ins;
    logic [15:0] pl;
    r = rows[i];
    case (r.op)
      OP_DISP:
      begin
        advance_cycle();
        next_payload(pl);
        ins         = r.ins;
        ins.valid   = 1'b1;
        ins.payload = pl;
        dispatch    = ins;
        #1;
        // a strobe is only legal while ready is high
        check_ready(row_name[i], 1'b1, dispatch_ready);
        rename_dispatch(ins, row_name[i]);
      end
      OP_WB:
      begin
        advance_cycle();
        complete_wb(r.seq);
      end
      OP_IDLE:
      begin
        advance_cycle();
        #1;
        check_ready(row_name[i], r.exp_rdy, dispatch_ready);
      end
      default:
      begin
        // run until nothing is owed or the oldest waits on a writeback
        while (exp_seq.size() != 0 && front_ready())
          advance_cycle();
      end
    endcase
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////////////////////

  task automatic build_table();
    // sources read the identity map, pdst from 16 up (seq 0..2)
    add_row("reset_map_a", OP_DISP, make_instr(1, 1, 1, 2, 1, 3), 0, 1'b1);
    add_row("reset_map_b", OP_DISP, make_instr(1, 4, 1, 5, 1, 6), 0, 1'b1);
    add_row("reset_map_c", OP_DISP, make_instr(1, 7, 1, 8, 1, 9), 0, 1'b1);
    add_row("reset_map_drain", OP_SETTLE, '0, 0, 1'b1);
    add_row("reset_map_wb_a", OP_WB, '0, 0, 1'b1);
    add_row("reset_map_wb_b", OP_WB, '0, 1, 1'b1);
    add_row("reset_map_wb_c", OP_WB, '0, 2, 1'b1);
    // consumer of a queued producer waits for its writeback (seq 3, 4)
    add_row("dep_producer", OP_DISP, make_instr(1, 10, 1, 1, 0, 0), 0, 1'b1);
    add_row("dep_consumer", OP_DISP, make_instr(1, 11, 1, 10, 1, 0), 0, 1'b1);
    add_row("dep_blocked", OP_SETTLE, '0, 0, 1'b1);
    add_row("dep_wb", OP_WB, '0, 3, 1'b1);
    add_row("dep_release", OP_SETTLE, '0, 0, 1'b1);
    add_row("dep_consumer_wb", OP_WB, '0, 4, 1'b1);
    // same logical register written twice (seq 5..7)
    add_row("waw_first", OP_DISP, make_instr(1, 12, 0, 0, 0, 0), 0, 1'b1);
    add_row("waw_second", OP_DISP, make_instr(1, 12, 1, 12, 0, 0), 0, 1'b1);
    add_row("waw_reader", OP_DISP, make_instr(0, 0, 1, 12, 0, 0), 0, 1'b1);
    add_row("waw_blocked", OP_SETTLE, '0, 0, 1'b1);
    add_row("waw_first_wb", OP_WB, '0, 5, 1'b1);
    add_row("waw_second_issue", OP_SETTLE, '0, 0, 1'b1);
    add_row("waw_second_wb", OP_WB, '0, 6, 1'b1);
    add_row("waw_drain", OP_SETTLE, '0, 0, 1'b1);
    // unused src1 points at a register still in flight (seq 8, 9)
    add_row("unused_src_writer", OP_DISP, make_instr(1, 14, 0, 0, 0, 0), 0, 1'b1);
    add_row("unused_src", OP_DISP, make_instr(0, 5, 0, 14, 1, 0), 0, 1'b1);
    add_row("unused_src_drain", OP_SETTLE, '0, 0, 1'b1);
    add_row("unused_src_wb", OP_WB, '0, 8, 1'b1);
    // four lines blocked behind one producer (seq 10..14)
    add_row("full_producer", OP_DISP, make_instr(1, 1, 0, 0, 0, 0), 0, 1'b1);
    add_row("full_line_b", OP_DISP, make_instr(1, 2, 1, 1, 0, 0), 0, 1'b1);
    add_row("full_line_c", OP_DISP, make_instr(0, 0, 1, 2, 1, 2), 0, 1'b1);
    add_row("full_line_d", OP_DISP, make_instr(1, 3, 1, 2, 0, 0), 0, 1'b1);
    add_row("full_line_e", OP_DISP, make_instr(0, 0, 1, 2, 0, 0), 0, 1'b1);
    add_row("full_ready_low", OP_IDLE, '0, 0, 1'b0);
    add_row("full_producer_wb", OP_WB, '0, 10, 1'b1);
    add_row("full_one_issue", OP_SETTLE, '0, 0, 1'b1);
    add_row("full_ready_high", OP_IDLE, '0, 0, 1'b1);
    add_row("full_line_b_wb", OP_WB, '0, 11, 1'b1);
    add_row("full_drain", OP_SETTLE, '0, 0, 1'b1);
    add_row("full_line_d_wb", OP_WB, '0, 13, 1'b1);
    // eat the rest of 16..63, then released ones come back in order
    for (int k = 0; k < 44; k++)
      add_row($sformatf("reuse_%0d", k), OP_DISP, make_instr(1, 15, 0, 0, 0, 0), 0, 1'b1);
    add_row("final_drain", OP_SETTLE, '0, 0, 1'b1);
  endtask

  initial
  begin
    dispatch   = '0;
    wb         = '0;
    cycles     = 0;
    n_disp     = 0;
    lfsr_state = 32'hcc4b;
    preg_rdy   = '0;
    for (int i = 0; i < NUM_LREG; i++)
    begin
      map_p[i]    = PREG_W'(i);
      preg_rdy[i] = 1'b1;
    end
    for (int i = NUM_LREG; i < NUM_PREG; i++)
      free_q.push_back(PREG_W'(i));
    build_table();
    limit = 20 * rows.size() + 100;

    while (rst_n !== 1'b1)
      advance_cycle();
    #1;
    check_ready("after_reset", 1'b1, dispatch_ready);

    for (int i = 0; i < rows.size(); i++)
      apply_row(i);

    if (exp_seq.size() != 0)
      abort_run("instructions still waiting in the queue at the end of the run");
    else
    begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule
